// ==== hdl/lsu_pkg.sv ====
/*
 * load-store unit shared types
 */
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // data and address width
  localparam int XLEN   = 32;
  // register index width
  localparam int RALEN  = 5;
  // bytes per word
  localparam int NBYTES = 4;

  ////////////////////////////////////////
  // command encoding
  ////////////////////////////////////////

  // bit 3 marks a write, bit 2 a zero-extending load
  // bits 1:0 code the size: 1 byte, 2 half, 3 word
  typedef enum logic [3:0] {
    LSU_NO_CMD      = 4'b0000,
    LSU_LOAD_BYTE   = 4'b0001,
    LSU_LOAD_HALF   = 4'b0010,
    LSU_LOAD_WORD   = 4'b0011,
    LSU_LOAD_BYTE_U = 4'b0101,
    LSU_LOAD_HALF_U = 4'b0110,
    LSU_STORE_BYTE  = 4'b1001,
    LSU_STORE_HALF  = 4'b1010,
    LSU_STORE_WORD  = 4'b1011
  } lsu_cmd_e;

  ////////////////////////////////////////
  // buffer payloads
  ////////////////////////////////////////

  // request as it goes out on the data bus
  typedef struct packed {
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   data;
    logic [NBYTES-1:0] strobe;
    logic              write;
    lsu_cmd_e          cmd;
    logic [RALEN-1:0]  regdest;
  } lsu_req_t;

  // what retirement needs to know about an issued request
  typedef struct packed {
    lsu_cmd_e         cmd;
    logic [1:0]       addr_lo;
    logic [XLEN-1:0]  addr;
    logic [RALEN-1:0] regdest;
  } lsu_act_t;

  // memory response
  typedef struct packed {
    logic [XLEN-1:0] data;
    logic            error;
  } lsu_rsp_t;

  ////////////////////////////////////////
  // command decode
  ////////////////////////////////////////

  function automatic logic cmd_is_write(input lsu_cmd_e cmd);
    return cmd[3];
  endfunction

  // access size in bytes, zero for no command
  function automatic logic [2:0] cmd_size(input lsu_cmd_e cmd);
    logic [2:0] size;
    case (cmd[1:0])
      2'd1:    size = 3'd1;
      2'd2:    size = 3'd2;
      2'd3:    size = 3'd4;
      default: size = 3'd0;
    endcase
    return size;
  endfunction

  function automatic logic cmd_is_unsigned(input lsu_cmd_e cmd);
    return cmd[2];
  endfunction

endpackage

`default_nettype wire

// ==== hdl/lsu_skid_buffer.sv ====
/*
 * two-entry skid buffer
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_skid_buffer #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rstn_i,
  // upstream side
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  input  wire payload_t in_data_i,
  // downstream side
  output logic          out_valid_o,
  input  wire logic     out_ready_i,
  output payload_t      out_data_o
);

  // second entry, filled only when the output is stalled
  logic     skid_valid;
  payload_t skid_data;
  logic     in_fire;
  logic     out_fire;
  logic     out_stalled;

  // ready comes straight from a flop, no path from out_ready_i
  assign in_ready_o  = !skid_valid;
  assign in_fire     = in_valid_i && in_ready_o;
  assign out_fire    = out_valid_o && out_ready_i;
  assign out_stalled = out_valid_o && !out_ready_i;

  ////////////////////////////////////////
  // occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      out_valid_o <= 1'b0;
      skid_valid  <= 1'b0;
    end else if (skid_valid) begin
      // output stays valid, the skid entry moves up
      if (out_ready_i) begin
        skid_valid <= 1'b0;
      end
    end else if (in_fire) begin
      if (out_stalled) begin
        skid_valid <= 1'b1;
      end else begin
        out_valid_o <= 1'b1;
      end
    end else if (out_fire) begin
      out_valid_o <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (skid_valid) begin
      if (out_ready_i) begin
        out_data_o <= skid_data;
      end
    end else if (in_fire) begin
      // park the new word if the output cannot move
      if (out_stalled) begin
        skid_data <= in_data_i;
      end else begin
        out_data_o <= in_data_i;
      end
    end
  end

  // the producer must hold off while both entries are taken
  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
    skid_valid |-> !in_valid_i);

endmodule

`default_nettype wire

// ==== hdl/lsu_core.sv ====
/*
 * load-store unit
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_core (
  input  wire logic                         clk_i,
  input  wire logic                         rstn_i,
  // core side
  input  wire logic                         lsu_valid_i,
  output logic                              lsu_ready_o,
  input  wire lsu_pkg::lsu_cmd_e            lsu_cmd_i,
  input  wire logic [lsu_pkg::XLEN-1:0]     lsu_addr_i,
  input  wire logic [lsu_pkg::XLEN-1:0]     lsu_data_i,
  input  wire logic [lsu_pkg::RALEN-1:0]    lsu_regdest_i,
  // register writeback
  output logic                              rf_wb_o,
  output logic [lsu_pkg::RALEN-1:0]         rf_dest_o,
  output logic [lsu_pkg::XLEN-1:0]          rf_data_o,
  // controller
  output logic                              ctrl_misaligned_load_o,
  output logic                              ctrl_misaligned_store_o,
  output logic                              ctrl_bus_error_o,
  output logic [lsu_pkg::XLEN-1:0]          ctrl_exception_addr_o,
  // data bus request
  output logic [lsu_pkg::XLEN-1:0]          data_req_addr_o,
  output logic [lsu_pkg::XLEN-1:0]          data_req_data_o,
  output logic [lsu_pkg::NBYTES-1:0]        data_req_strobe_o,
  output logic                              data_req_write_o,
  output logic                              data_req_valid_o,
  input  wire logic                         data_req_ready_i,
  // data bus response, always accepted
  input  wire logic [lsu_pkg::XLEN-1:0]     data_rsp_data_i,
  input  wire logic                         data_rsp_error_i,
  input  wire logic                         data_rsp_valid_i
);

  typedef enum logic [1:0] {
    ST_RUN,    // taking requests
    ST_READ,   // waiting for a load to retire
    ST_STALL   // a buffer is full
  } state_e;

  state_e state;
  state_e state_next;

  // buffer ends
  lsu_pkg::lsu_req_t req_in;
  lsu_pkg::lsu_req_t req_out;
  logic              req_in_valid;
  logic              req_in_ready;
  lsu_pkg::lsu_act_t act_in;
  lsu_pkg::lsu_act_t act_out;
  logic              act_in_ready;
  logic              act_out_valid;
  lsu_pkg::lsu_rsp_t rsp_in;
  lsu_pkg::lsu_rsp_t rsp_out;
  logic              rsp_out_valid;

  // input decode
  logic [2:0]                  in_size;
  logic                        in_write;
  logic                        in_misaligned;
  logic [lsu_pkg::NBYTES-1:0]  in_strobe;
  logic                        in_fire;
  logic                        inflight;

  logic                        data_req_fire;
  logic                        retire;
  logic                        load_retire;
  logic [lsu_pkg::XLEN-1:0]    rsp_word;
  logic                        ext_signed;
  logic [lsu_pkg::XLEN-1:0]    mis_addr_q;

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  always_comb begin
    in_size  = lsu_pkg::cmd_size(lsu_cmd_i);
    in_write = lsu_pkg::cmd_is_write(lsu_cmd_i);
    // a 2^n byte access needs its low n address bits clear
    in_misaligned = |(lsu_addr_i[1:0] & 2'(in_size - 3'd1));
    case (in_size)
      3'd1:    in_strobe = 4'b0001;
      3'd2:    in_strobe = 4'b0011;
      3'd4:    in_strobe = 4'b1111;
      default: in_strobe = 4'b0000;
    endcase
    // move strobe and data into the lanes of the addressed bytes
    req_in.addr    = lsu_addr_i;
    req_in.data    = lsu_data_i << {lsu_addr_i[1:0], 3'b000};
    req_in.strobe  = in_strobe << lsu_addr_i[1:0];
    req_in.write   = in_write;
    req_in.cmd     = lsu_cmd_i;
    req_in.regdest = lsu_regdest_i;
  end

  // something is issued or waiting for its response
  assign inflight = data_req_valid_o || act_out_valid;

  // misaligned requests wait for older requests so exceptions stay in order
  assign lsu_ready_o  = (state == ST_RUN) && req_in_ready && act_in_ready &&
                        !(in_misaligned && inflight);
  assign in_fire      = lsu_valid_i && lsu_ready_o;
  assign req_in_valid = in_fire && !in_misaligned;

  ////////////////////////////////////////
  // buffers
  ////////////////////////////////////////

  lsu_skid_buffer #(
    .payload_t (lsu_pkg::lsu_req_t)
  ) i_req_buffer (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_valid_i  (req_in_valid),
    .in_ready_o  (req_in_ready),
    .in_data_i   (req_in),
    .out_valid_o (data_req_valid_o),
    .out_ready_i (data_req_ready_i),
    .out_data_o  (req_out)
  );

  assign data_req_addr_o   = req_out.addr;
  assign data_req_data_o   = req_out.data;
  assign data_req_strobe_o = req_out.strobe;
  assign data_req_write_o  = req_out.write;
  assign data_req_fire     = data_req_valid_o && data_req_ready_i;

  // issued requests wait here for their responses
  always_comb begin
    act_in.cmd     = req_out.cmd;
    act_in.addr_lo = req_out.addr[1:0];
    act_in.addr    = req_out.addr;
    act_in.regdest = req_out.regdest;
  end

  lsu_skid_buffer #(
    .payload_t (lsu_pkg::lsu_act_t)
  ) i_act_buffer (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_valid_i  (data_req_fire),
    .in_ready_o  (act_in_ready),
    .in_data_i   (act_in),
    .out_valid_o (act_out_valid),
    .out_ready_i (retire),
    .out_data_o  (act_out)
  );

  assign rsp_in.data  = data_rsp_data_i;
  assign rsp_in.error = data_rsp_error_i;

  // responses have no back-pressure, overflow is caught inside
  lsu_skid_buffer #(
    .payload_t (lsu_pkg::lsu_rsp_t)
  ) i_rsp_buffer (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_valid_i  (data_rsp_valid_i),
    .in_ready_o  (),
    .in_data_i   (rsp_in),
    .out_valid_o (rsp_out_valid),
    .out_ready_i (retire),
    .out_data_o  (rsp_out)
  );

  ////////////////////////////////////////
  // retirement
  ////////////////////////////////////////

  // oldest request pairs with oldest response
  assign retire      = rsp_out_valid && act_out_valid;
  assign load_retire = retire && !lsu_pkg::cmd_is_write(act_out.cmd);

  always_comb begin
    rsp_word   = rsp_out.data >> {act_out.addr_lo, 3'b000};
    ext_signed = !lsu_pkg::cmd_is_unsigned(act_out.cmd);
    case (lsu_pkg::cmd_size(act_out.cmd))
      3'd1:    rf_data_o = {{24{ext_signed & rsp_word[7]}}, rsp_word[7:0]};
      3'd2:    rf_data_o = {{16{ext_signed & rsp_word[15]}}, rsp_word[15:0]};
      default: rf_data_o = rsp_word;
    endcase
  end

  // an errored load writes nothing back
  assign rf_wb_o          = load_retire && !rsp_out.error;
  assign rf_dest_o        = act_out.regdest;
  assign ctrl_bus_error_o = retire && rsp_out.error;

  ////////////////////////////////////////
  // misaligned exceptions
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ctrl_misaligned_load_o  <= 1'b0;
      ctrl_misaligned_store_o <= 1'b0;
    end else begin
      ctrl_misaligned_load_o  <= in_fire && in_misaligned && !in_write;
      ctrl_misaligned_store_o <= in_fire && in_misaligned && in_write;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      mis_addr_q <= lsu_addr_i;
    end
  end

  // bus errors report the retiring request's address
  assign ctrl_exception_addr_o = ctrl_bus_error_o ? act_out.addr : mis_addr_q;

  ////////////////////////////////////////
  // stall FSM
  ////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      ST_RUN: begin
        if (req_in_valid && !in_write) begin
          state_next = ST_READ;
        end else if (!req_in_ready || !act_in_ready) begin
          state_next = ST_STALL;
        end
      end
      ST_READ: begin
        // stores ahead of the load retire first
        if (load_retire) begin
          state_next = ST_RUN;
        end
      end
      ST_STALL: begin
        if (req_in_ready && act_in_ready) begin
          state_next = ST_RUN;
        end
      end
      default: state_next = ST_RUN;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state <= ST_RUN;
    end else begin
      state <= state_next;
    end
  end

  // memory never answers a request that was not issued
  a_rsp_has_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rsp_out_valid |-> act_out_valid);

  // after a load goes in, nothing else is taken until it retires
  a_load_blocks: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (req_in_valid && !in_write) |=> !in_fire until_with load_retire);

endmodule

`default_nettype wire

// ==== hdl/lsu_data_ram.sv ====
/*
 * data memory model
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_data_ram #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 2
) (
  input  wire logic                        clk_i,
  input  wire logic                        rstn_i,
  // request channel
  input  wire logic [lsu_pkg::XLEN-1:0]    data_req_addr_i,
  input  wire logic [lsu_pkg::XLEN-1:0]    data_req_data_i,
  input  wire logic [lsu_pkg::NBYTES-1:0]  data_req_strobe_i,
  input  wire logic                        data_req_write_i,
  input  wire logic                        data_req_valid_i,
  output logic                             data_req_ready_o,
  // response channel
  output logic [lsu_pkg::XLEN-1:0]         data_rsp_data_o,
  output logic                             data_rsp_error_o,
  output logic                             data_rsp_valid_o
);

  localparam int AW = $clog2(MEM_WORDS);
  // wide enough to hold WAIT_STATES, also when it is zero
  localparam int CW = $clog2(WAIT_STATES + 2);

  logic [lsu_pkg::XLEN-1:0] mem [MEM_WORDS];

  logic                     busy;
  logic [CW-1:0]            wait_cnt;
  logic [lsu_pkg::XLEN-3:0] word_idx;
  logic                     in_range;
  logic                     req_fire;
  logic [lsu_pkg::XLEN-1:0] rd_data_q;
  logic                     err_q;

  assign word_idx = data_req_addr_i[lsu_pkg::XLEN-1:2];
  assign in_range = word_idx < (lsu_pkg::XLEN-2)'(MEM_WORDS);

  // one access at a time
  assign data_req_ready_o = !busy;
  assign req_fire         = data_req_valid_i && data_req_ready_o;

  ////////////////////////////////////////
  // wait-state counter
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      busy     <= 1'b0;
      wait_cnt <= '0;
    end else if (req_fire) begin
      busy     <= 1'b1;
      wait_cnt <= CW'(WAIT_STATES);
    end else if (busy) begin
      // port frees up after the response cycle
      if (wait_cnt == '0) begin
        busy <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // array access
  ////////////////////////////////////////

  // the access happens on acceptance, the answer waits out the counter
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      err_q <= !in_range;
      if (in_range && !data_req_write_i) begin
        rd_data_q <= mem[word_idx[AW-1:0]];
      end else begin
        // writes and out of range reads answer zero
        rd_data_q <= '0;
      end
      if (in_range && data_req_write_i) begin
        for (int b = 0; b < lsu_pkg::NBYTES; b++) begin
          if (data_req_strobe_i[b]) begin
            mem[word_idx[AW-1:0]][8*b +: 8] <= data_req_data_i[8*b +: 8];
          end
        end
      end
    end
  end

  assign data_rsp_valid_o = busy && (wait_cnt == '0);
  assign data_rsp_data_o  = rd_data_q;
  assign data_rsp_error_o = err_q;

  // each response answers the request taken WAIT_STATES+1 cycles earlier
  a_rsp_after_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
    data_rsp_valid_o |-> $past(req_fire, WAIT_STATES + 1));

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
/*
 * load-store unit with data memory
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_top #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 2
) (
  input  wire logic                        clk_i,
  input  wire logic                        rstn_i,
  // core side
  input  wire logic                        lsu_valid_i,
  output logic                             lsu_ready_o,
  input  wire lsu_pkg::lsu_cmd_e           lsu_cmd_i,
  input  wire logic [lsu_pkg::XLEN-1:0]    lsu_addr_i,
  input  wire logic [lsu_pkg::XLEN-1:0]    lsu_data_i,
  input  wire logic [lsu_pkg::RALEN-1:0]   lsu_regdest_i,
  // register writeback
  output logic                             rf_wb_o,
  output logic [lsu_pkg::RALEN-1:0]        rf_dest_o,
  output logic [lsu_pkg::XLEN-1:0]         rf_data_o,
  // controller
  output logic                             ctrl_misaligned_load_o,
  output logic                             ctrl_misaligned_store_o,
  output logic                             ctrl_bus_error_o,
  output logic [lsu_pkg::XLEN-1:0]         ctrl_exception_addr_o
);

  // request channel
  logic [lsu_pkg::XLEN-1:0]   data_req_addr;
  logic [lsu_pkg::XLEN-1:0]   data_req_data;
  logic [lsu_pkg::NBYTES-1:0] data_req_strobe;
  logic                       data_req_write;
  logic                       data_req_valid;
  logic                       data_req_ready;
  // response channel
  logic [lsu_pkg::XLEN-1:0]   data_rsp_data;
  logic                       data_rsp_error;
  logic                       data_rsp_valid;

  lsu_core i_lsu_core (
    .clk_i                   (clk_i),
    .rstn_i                  (rstn_i),
    .lsu_valid_i             (lsu_valid_i),
    .lsu_ready_o             (lsu_ready_o),
    .lsu_cmd_i               (lsu_cmd_i),
    .lsu_addr_i              (lsu_addr_i),
    .lsu_data_i              (lsu_data_i),
    .lsu_regdest_i           (lsu_regdest_i),
    .rf_wb_o                 (rf_wb_o),
    .rf_dest_o               (rf_dest_o),
    .rf_data_o               (rf_data_o),
    .ctrl_misaligned_load_o  (ctrl_misaligned_load_o),
    .ctrl_misaligned_store_o (ctrl_misaligned_store_o),
    .ctrl_bus_error_o        (ctrl_bus_error_o),
    .ctrl_exception_addr_o   (ctrl_exception_addr_o),
    .data_req_addr_o         (data_req_addr),
    .data_req_data_o         (data_req_data),
    .data_req_strobe_o       (data_req_strobe),
    .data_req_write_o        (data_req_write),
    .data_req_valid_o        (data_req_valid),
    .data_req_ready_i        (data_req_ready),
    .data_rsp_data_i         (data_rsp_data),
    .data_rsp_error_i        (data_rsp_error),
    .data_rsp_valid_i        (data_rsp_valid)
  );

  lsu_data_ram #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) i_lsu_data_ram (
    .clk_i             (clk_i),
    .rstn_i            (rstn_i),
    .data_req_addr_i   (data_req_addr),
    .data_req_data_i   (data_req_data),
    .data_req_strobe_i (data_req_strobe),
    .data_req_write_i  (data_req_write),
    .data_req_valid_i  (data_req_valid),
    .data_req_ready_o  (data_req_ready),
    .data_rsp_data_o   (data_rsp_data),
    .data_rsp_error_o  (data_rsp_error),
    .data_rsp_valid_o  (data_rsp_valid)
  );

endmodule

`default_nettype wire

// ==== bench/lsu_checker.sv ====
/*
 * load-store unit outcome checker
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_checker #(
  parameter int TIMEOUT = 200
) (
  input  wire logic                         clk_i,
  input  wire logic                         rstn_i,
  // core side handshake
  input  wire logic                         lsu_valid_i,
  input  wire logic                         lsu_ready_i,
  input  wire lsu_pkg::lsu_cmd_e            lsu_cmd_i,
  // outcome pulses from the DUT
  input  wire logic                         rf_wb_i,
  input  wire logic [lsu_pkg::RALEN-1:0]    rf_dest_i,
  input  wire logic [lsu_pkg::XLEN-1:0]     rf_data_i,
  input  wire logic                         mis_load_i,
  input  wire logic                         mis_store_i,
  input  wire logic                         bus_error_i,
  input  wire logic [lsu_pkg::XLEN-1:0]     exc_addr_i,
  // kind bits are writeback, misaligned load, misaligned store, bus error
  input  wire logic                         exp_push_i,
  input  wire logic [3:0]                   exp_kind_i,
  input  wire logic                         exp_is_load_i,
  input  wire logic [lsu_pkg::XLEN-1:0]     exp_addr_i,
  input  wire logic [lsu_pkg::XLEN-1:0]     exp_data_i,
  input  wire logic [lsu_pkg::RALEN-1:0]    exp_dest_i,
  // error counts
  output int                                mismatch_count_o,
  output int                                protocol_count_o,
  output int                                timeout_count_o,
  output int                                outstanding_o
);

  typedef struct packed {
    logic [3:0]                kind;
    logic                      is_load;
    logic [lsu_pkg::XLEN-1:0]  addr;
    logic [lsu_pkg::XLEN-1:0]  data;
    logic [lsu_pkg::RALEN-1:0] dest;
  } expect_t;

  // expected outcomes in request order
  expect_t    exp_q[$];
  expect_t    head;
  logic [3:0] pulses;
  logic       load_pending;
  logic       seen_request;
  int         idle_cycles;

  initial begin
    mismatch_count_o = 0;
    protocol_count_o = 0;
    timeout_count_o  = 0;
    outstanding_o    = 0;
    load_pending     = 1'b0;
    seen_request     = 1'b0;
    idle_cycles      = 0;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
      mismatch_count_o++;
    end
  endtask

  task automatic compare_outcome(input expect_t e);
    compare_value("rf_wb_o", e.kind[3], rf_wb_i);
    compare_value("ctrl_misaligned_load_o", e.kind[2], mis_load_i);
    compare_value("ctrl_misaligned_store_o", e.kind[1], mis_store_i);
    compare_value("ctrl_bus_error_o", e.kind[0], bus_error_i);
    if (e.kind[3]) begin
      compare_value("rf_dest_o", e.dest, rf_dest_i);
      compare_value("rf_data_o", e.data, rf_data_i);
    end else begin
      compare_value("ctrl_exception_addr_o", e.addr, exc_addr_i);
    end
  endtask

  ////////////////////////////////////////
  // sampling at the falling edge
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rstn_i) begin
      // new expectation first, its misaligned pulse may already be here
      if (exp_push_i) begin
        exp_q.push_back({exp_kind_i, exp_is_load_i, exp_addr_i, exp_data_i, exp_dest_i});
      end
      pulses = {rf_wb_i, mis_load_i, mis_store_i, bus_error_i};
      if (pulses != 4'b0000) begin
        idle_cycles = 0;
        if (exp_q.size() == 0) begin
          $display("outcome pulse at %0t with no request waiting for one", $time);
          protocol_count_o++;
        end else begin
          head = exp_q.pop_front();
          compare_outcome(head);
          if (head.is_load) begin
            load_pending = 1'b0;
          end
        end
      end else if (exp_q.size() != 0) begin
        idle_cycles++;
        if (idle_cycles > TIMEOUT) begin
          head = exp_q.pop_front();
          $display("no outcome within %0d cycles for the request at %h", TIMEOUT, head.addr);
          timeout_count_o++;
          idle_cycles = 0;
          if (head.is_load) begin
            load_pending = 1'b0;
          end
        end
      end else begin
        idle_cycles = 0;
      end
      // a load holds off the core until it completes
      if (load_pending && lsu_ready_i) begin
        $display("lsu_ready_o high at %0t while a load is still outstanding", $time);
        protocol_count_o++;
      end
      if (!seen_request && !lsu_ready_i) begin
        $display("lsu_ready_o low at %0t after reset before any request", $time);
        protocol_count_o++;
      end
      if (lsu_valid_i && lsu_ready_i) begin
        seen_request = 1'b1;
        if (!(lsu_cmd_i inside {lsu_pkg::LSU_STORE_BYTE, lsu_pkg::LSU_STORE_HALF,
                                lsu_pkg::LSU_STORE_WORD})) begin
          load_pending = 1'b1;
        end
      end
      outstanding_o = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_lsu.sv ====
/*
 * load-store unit testbench
 */
`timescale 1ns/1ns
`default_nettype none

module tb_lsu;

  localparam int MEM_WORDS   = 256;
  localparam int WAIT_STATES = 2;
  localparam int NUM_OPS     = 600;
  localparam int TIMEOUT     = 200;

  // outcome kinds with one bit per pulse in checker order
  localparam logic [3:0] KIND_WB        = 4'b1000;
  localparam logic [3:0] KIND_MIS_LOAD  = 4'b0100;
  localparam logic [3:0] KIND_MIS_STORE = 4'b0010;
  localparam logic [3:0] KIND_BUS_ERROR = 4'b0001;

  logic                      clk;
  logic                      rstn;
  // core side
  logic                      lsu_valid;
  logic                      lsu_ready;
  lsu_pkg::lsu_cmd_e         lsu_cmd;
  logic [lsu_pkg::XLEN-1:0]  lsu_addr;
  logic [lsu_pkg::XLEN-1:0]  lsu_data;
  logic [lsu_pkg::RALEN-1:0] lsu_regdest;
  // outcomes
  logic                      rf_wb;
  logic [lsu_pkg::RALEN-1:0] rf_dest;
  logic [lsu_pkg::XLEN-1:0]  rf_data;
  logic                      mis_load;
  logic                      mis_store;
  logic                      bus_error;
  logic [lsu_pkg::XLEN-1:0]  exc_addr;
  // expectations for the checker
  logic                      exp_push;
  logic [3:0]                exp_kind;
  logic                      exp_is_load;
  logic [lsu_pkg::XLEN-1:0]  exp_addr;
  logic [lsu_pkg::XLEN-1:0]  exp_data;
  logic [lsu_pkg::RALEN-1:0] exp_dest;

  // mirror of the data memory
  logic [31:0] mirror [MEM_WORDS];

  int mismatch_count;
  int protocol_count;
  int checker_timeouts;
  int outstanding;
  int drive_timeouts;
  int total_errors;
  int drain_wait;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  lsu_top #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) i_lsu_top (
    .clk_i                   (clk),
    .rstn_i                  (rstn),
    .lsu_valid_i             (lsu_valid),
    .lsu_ready_o             (lsu_ready),
    .lsu_cmd_i               (lsu_cmd),
    .lsu_addr_i              (lsu_addr),
    .lsu_data_i              (lsu_data),
    .lsu_regdest_i           (lsu_regdest),
    .rf_wb_o                 (rf_wb),
    .rf_dest_o               (rf_dest),
    .rf_data_o               (rf_data),
    .ctrl_misaligned_load_o  (mis_load),
    .ctrl_misaligned_store_o (mis_store),
    .ctrl_bus_error_o        (bus_error),
    .ctrl_exception_addr_o   (exc_addr)
  );

  lsu_checker #(
    .TIMEOUT (TIMEOUT)
  ) i_lsu_checker (
    .clk_i            (clk),
    .rstn_i           (rstn),
    .lsu_valid_i      (lsu_valid),
    .lsu_ready_i      (lsu_ready),
    .lsu_cmd_i        (lsu_cmd),
    .rf_wb_i          (rf_wb),
    .rf_dest_i        (rf_dest),
    .rf_data_i        (rf_data),
    .mis_load_i       (mis_load),
    .mis_store_i      (mis_store),
    .bus_error_i      (bus_error),
    .exc_addr_i       (exc_addr),
    .exp_push_i       (exp_push),
    .exp_kind_i       (exp_kind),
    .exp_is_load_i    (exp_is_load),
    .exp_addr_i       (exp_addr),
    .exp_data_i       (exp_data),
    .exp_dest_i       (exp_dest),
    .mismatch_count_o (mismatch_count),
    .protocol_count_o (protocol_count),
    .timeout_count_o  (checker_timeouts),
    .outstanding_o    (outstanding)
  );

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // initial memory image where every address bit matters
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  // outcome of one accepted request and the store update of the mirror
  task automatic model_request(input lsu_pkg::lsu_cmd_e cmd, input logic [31:0] addr,
                               input logic [31:0] data, input logic [4:0] dest);
    int          size;
    int          lo;
    logic        is_store;
    logic        is_unsigned;
    logic [29:0] widx;
    logic [31:0] word;
    case (cmd)
      lsu_pkg::LSU_LOAD_BYTE, lsu_pkg::LSU_LOAD_BYTE_U, lsu_pkg::LSU_STORE_BYTE: size = 1;
      lsu_pkg::LSU_LOAD_HALF, lsu_pkg::LSU_LOAD_HALF_U, lsu_pkg::LSU_STORE_HALF: size = 2;
      default: size = 4;
    endcase
    is_store = cmd inside {lsu_pkg::LSU_STORE_BYTE, lsu_pkg::LSU_STORE_HALF,
                           lsu_pkg::LSU_STORE_WORD};
    is_unsigned = cmd inside {lsu_pkg::LSU_LOAD_BYTE_U, lsu_pkg::LSU_LOAD_HALF_U};
    widx = addr[31:2];
    lo   = addr[1:0];
    exp_push    <= 1'b1;
    exp_is_load <= !is_store;
    exp_addr    <= addr;
    exp_dest    <= dest;
    exp_data    <= '0;
    if ((lo % size) != 0) begin
      exp_kind <= is_store ? KIND_MIS_STORE : KIND_MIS_LOAD;
    end else if (widx >= MEM_WORDS) begin
      exp_kind <= KIND_BUS_ERROR;
    end else if (is_store) begin
      // stores in range leave no outcome
      exp_push <= 1'b0;
      for (int b = 0; b < size; b++) begin
        mirror[widx][8*(lo+b) +: 8] = data[8*b +: 8];
      end
    end else begin
      word = mirror[widx] >> (8 * lo);
      if (size == 1) begin
        word = is_unsigned ? {24'h0, word[7:0]} : {{24{word[7]}}, word[7:0]};
      end else if (size == 2) begin
        word = is_unsigned ? {16'h0, word[15:0]} : {{16{word[15]}}, word[15:0]};
      end
      exp_kind <= KIND_WB;
      exp_data <= word;
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // hold one request until the unit takes it
  task automatic send_request(input lsu_pkg::lsu_cmd_e cmd, input logic [31:0] addr,
                              input logic [31:0] data, input logic [4:0] dest);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    lsu_valid   <= 1'b1;
    lsu_cmd     <= cmd;
    lsu_addr    <= addr;
    lsu_data    <= data;
    lsu_regdest <= dest;
    while (!taken && waited < TIMEOUT) begin
      @(negedge clk);
      taken = lsu_ready;
      @(posedge clk);
      exp_push <= 1'b0;
      waited++;
    end
    if (taken) begin
      model_request(cmd, addr, data, dest);
    end else begin
      $display("request at %h was not accepted within %0d cycles", addr, TIMEOUT);
      drive_timeouts++;
    end
  endtask

  task automatic idle_cycle();
    lsu_valid <= 1'b0;
    @(posedge clk);
    exp_push <= 1'b0;
  endtask

  // mostly in range with some misaligned and some beyond the memory
  task automatic random_request();
    lsu_pkg::lsu_cmd_e cmd;
    logic [1:0]        mask;
    logic [31:0]       addr;
    int                pick;
    int                widx;
    case ($urandom_range(0, 7))
      0:       cmd = lsu_pkg::LSU_LOAD_BYTE;
      1:       cmd = lsu_pkg::LSU_LOAD_HALF;
      2:       cmd = lsu_pkg::LSU_LOAD_WORD;
      3:       cmd = lsu_pkg::LSU_LOAD_BYTE_U;
      4:       cmd = lsu_pkg::LSU_LOAD_HALF_U;
      5:       cmd = lsu_pkg::LSU_STORE_BYTE;
      6:       cmd = lsu_pkg::LSU_STORE_HALF;
      default: cmd = lsu_pkg::LSU_STORE_WORD;
    endcase
    // low address bits that keep the access aligned
    case (cmd)
      lsu_pkg::LSU_LOAD_BYTE, lsu_pkg::LSU_LOAD_BYTE_U, lsu_pkg::LSU_STORE_BYTE: mask = 2'b11;
      lsu_pkg::LSU_LOAD_HALF, lsu_pkg::LSU_LOAD_HALF_U, lsu_pkg::LSU_STORE_HALF: mask = 2'b10;
      default: mask = 2'b00;
    endcase
    pick = $urandom_range(0, 99);
    // a small window makes loads hit recent stores
    widx = (pick < 55) ? $urandom_range(0, 15) : $urandom_range(0, MEM_WORDS - 1);
    if (pick < 10) begin
      addr = 32'((MEM_WORDS + $urandom_range(0, 1023)) * 4);
    end else if (pick < 20) begin
      addr = 32'(widx * 4 + $urandom_range(1, 3));
    end else begin
      addr = 32'(widx * 4) | 32'($urandom_range(0, 3) & mask);
    end
    send_request(cmd, addr, $urandom(), 5'($urandom_range(0, 31)));
  endtask

  initial begin
    void'($urandom(32'he3a6_f712));
    rstn        = 1'b0;
    lsu_valid   = 1'b0;
    lsu_cmd     = lsu_pkg::LSU_NO_CMD;
    lsu_addr    = '0;
    lsu_data    = '0;
    lsu_regdest = '0;
    exp_push    = 1'b0;
    exp_kind    = '0;
    exp_is_load = 1'b0;
    exp_addr    = '0;
    exp_data    = '0;
    exp_dest    = '0;
    drive_timeouts = 0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    // a few quiet cycles to look at the reset state
    repeat (4) @(posedge clk);
    for (int i = 0; i < MEM_WORDS && drive_timeouts == 0; i++) begin
      send_request(lsu_pkg::LSU_STORE_WORD, 32'(i * 4), fill_word(32'(i * 4)), '0);
    end
    for (int n = 0; n < NUM_OPS && drive_timeouts == 0; n++) begin
      if ($urandom_range(0, 4) == 0) begin
        idle_cycle();
      end else begin
        random_request();
      end
    end
    idle_cycle();
    drain_wait = 0;
    while (outstanding != 0 && drain_wait < TIMEOUT) begin
      @(posedge clk);
      drain_wait++;
    end
    if (outstanding != 0) begin
      $display("%0d outcomes still missing after %0d cycles", outstanding, TIMEOUT);
      drive_timeouts++;
    end
    repeat (10) @(posedge clk);
    total_errors = mismatch_count + protocol_count + checker_timeouts + drive_timeouts;
    $display("errors: %0d mismatch, %0d protocol, %0d timeout", mismatch_count,
             protocol_count, checker_timeouts + drive_timeouts);
    if (total_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/lsu_pkg.sv
hdl/lsu_skid_buffer.sv
hdl/lsu_core.sv
hdl/lsu_data_ram.sv
hdl/lsu_top.sv
bench/lsu_checker.sv
bench/tb_lsu.sv
